// File: id_stage_params.svh
`ifndef ID_STAGE_PARAMS_SVH
`define ID_STAGE_PARAMS_SVH

// Datapath and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_IDX_W 5

`define INST_W 32
`define PC_STEP 4  // Fall-through increment

`endif

// File: rv_isa_pkg.sv
`include "id_stage_params.svh"

package rv_isa_pkg;

    // Major opcodes kept by this decoder
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_type_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    // R-type layout, bit 31 on the left
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_fields_t;

endpackage

// File: id_pipe_pkg.sv
`include "id_stage_params.svh"

package id_pipe_pkg;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic [`INST_W-1:0]    inst;
        logic                  prediction_valid;
        logic [`XLEN-1:0]      predicted_pc;  // From the fetch-stage predictor
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`REG_IDX_W-1:0]  rs2;
        rv_isa_pkg::alu_op_e    alu_op;
        logic                   alu_src1_sel;  // 1 picks pc
        logic                   alu_src2_sel;  // 1 picks imm
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        rv_isa_pkg::mem_width_e mem_width;
        logic                   mem_unsigned;
        logic                   is_branch;
        rv_isa_pkg::br_type_e   branch_type;
        logic                   is_jump;
        logic                   prediction_valid;
        logic [`XLEN-1:0]       predicted_pc;
    } id_ex_t;

    // Same tap shape for EX/MEM and MEM/WB
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      result;
    } fwd_src_t;

    typedef struct packed {
        logic                  enable;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  id_pipe_pkg::wb_t      wb,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wb_write;

    assign wb_write = wb.enable && (wb.rd != '0);  // x0 is never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Read ports, same-cycle write-back wins over the stored value
    assign rs1_data = (rs1_idx == '0) ? '0 :
                      (wb_write && wb.rd == rs1_idx) ? wb.data : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 :
                      (wb_write && wb.rd == rs2_idx) ? wb.data : regs[rs2_idx];

    a_wb_rd_known: assert property (@(posedge clk) disable iff (rst)
        wb.enable |-> !$isunknown(wb.rd))
        else $error("reg_file: write-back enabled with unknown rd");

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module inst_decoder (
    input  logic                  flush,
    input  id_pipe_pkg::if_id_t   if_id,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output logic [`REG_IDX_W-1:0] rs1_idx,
    output logic [`REG_IDX_W-1:0] rs2_idx,
    output logic [`XLEN-1:0]      imm_b,
    output id_pipe_pkg::id_ex_t   id_ex_next
);

    import rv_isa_pkg::*;

    logic [`INST_W-1:0] inst;
    inst_fields_t       f;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;

    // Used by OP and OP-IMM where only OP has SUB
    function automatic alu_op_e alu_of(input logic [2:0] funct3, input logic sub_ok,
                                       input logic alt);
        case (funct3)
            3'b000:  return (sub_ok && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic mem_width_e width_of(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00:   return MEM_BYTE;
            2'b01:   return MEM_HALF;
            default: return MEM_WORD;
        endcase
    endfunction

    function automatic br_type_e br_of(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    assign inst    = if_id.inst;
    assign f       = inst;
    assign rs1_idx = f.rs1;
    assign rs2_idx = f.rs2;

    // --------------------
    // Immediates
    // --------------------
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // --------------------
    // Control decode
    // --------------------
    always_comb begin
        id_ex_next = '0;
        if (!flush && if_id.valid) begin
            id_ex_next.valid            = 1'b1;
            id_ex_next.pc               = if_id.pc;
            id_ex_next.rs1_data         = rs1_data;
            id_ex_next.rs2_data         = rs2_data;
            id_ex_next.rd               = f.rd;
            id_ex_next.rs1              = f.rs1;
            id_ex_next.rs2              = f.rs2;
            id_ex_next.prediction_valid = if_id.prediction_valid;
            id_ex_next.predicted_pc     = if_id.predicted_pc;
            id_ex_next.alu_op           = ALU_ADD;  // Address math unless overridden
            id_ex_next.alu_src2_sel     = 1'b1;
            case (f.opcode)
                OP_LUI: begin
                    id_ex_next.imm       = imm_u;
                    id_ex_next.alu_op    = ALU_LUI;
                    id_ex_next.reg_write = 1'b1;
                end
                OP_AUIPC: begin
                    id_ex_next.imm          = imm_u;
                    id_ex_next.alu_op       = ALU_AUIPC;
                    id_ex_next.alu_src1_sel = 1'b1;
                    id_ex_next.reg_write    = 1'b1;
                end
                OP_JAL: begin
                    id_ex_next.imm          = imm_j;
                    id_ex_next.alu_src1_sel = 1'b1;
                    id_ex_next.is_jump      = 1'b1;
                    id_ex_next.reg_write    = 1'b1;
                end
                OP_JALR: begin
                    id_ex_next.imm       = imm_i;
                    id_ex_next.is_jump   = 1'b1;
                    id_ex_next.reg_write = 1'b1;
                end
                OP_BRANCH: begin
                    id_ex_next.imm          = imm_b;
                    id_ex_next.alu_src1_sel = 1'b1;  // pc + imm target
                    id_ex_next.is_branch    = 1'b1;
                    id_ex_next.branch_type  = br_of(f.funct3);
                end
                OP_LOAD: begin
                    id_ex_next.imm          = imm_i;
                    id_ex_next.mem_read     = 1'b1;
                    id_ex_next.reg_write    = 1'b1;
                    id_ex_next.mem_width    = width_of(f.funct3);
                    id_ex_next.mem_unsigned = f.funct3[2];  // LBU and LHU
                end
                OP_STORE: begin
                    id_ex_next.imm       = imm_s;
                    id_ex_next.mem_write = 1'b1;
                    id_ex_next.mem_width = width_of(f.funct3);
                end
                OP_IMM: begin
                    id_ex_next.imm       = imm_i;
                    id_ex_next.alu_op    = alu_of(f.funct3, 1'b0, f.funct7[5]);
                    id_ex_next.reg_write = 1'b1;
                end
                OP_REG: begin
                    id_ex_next.alu_src2_sel = 1'b0;  // rs2 operand
                    id_ex_next.alu_op       = alu_of(f.funct3, 1'b1, f.funct7[5]);
                    id_ex_next.reg_write    = 1'b1;
                end
                default: id_ex_next = '0;  // SYSTEM, FENCE and unknown
            endcase
        end
    end

    // A valid instruction must be fully known
    always_comb begin
        a_inst_known: assert final (!if_id.valid || !$isunknown(if_id.inst))
            else $error("inst_decoder: valid instruction with unknown bits");
    end

endmodule

// File: operand_bypass.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module operand_bypass (
    input  logic [`REG_IDX_W-1:0] reg_idx,
    input  logic [`XLEN-1:0]      reg_data,
    input  id_pipe_pkg::fwd_src_t ex_mem_fwd,
    input  id_pipe_pkg::fwd_src_t mem_wb_fwd,
    input  logic [`XLEN-1:0]      wb_data,
    output logic [`XLEN-1:0]      operand
);

    import id_pipe_pkg::*;

    logic ex_mem_hit;
    logic mem_wb_hit;

    // Tap writes the register we are reading
    function automatic logic tap_hit(input fwd_src_t tap, input logic [`REG_IDX_W-1:0] idx);
        return tap.valid && tap.reg_write && (tap.rd != '0) && (tap.rd == idx);
    endfunction

    assign ex_mem_hit = tap_hit(ex_mem_fwd, reg_idx);
    assign mem_wb_hit = tap_hit(mem_wb_fwd, reg_idx);

    // Youngest producer first
    assign operand = ex_mem_hit ? ex_mem_fwd.result :
                     mem_wb_hit ? wb_data :
                                  reg_data;

endmodule

// File: branch_resolver.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module branch_resolver (
    input  id_pipe_pkg::if_id_t    if_id,
    input  logic [`XLEN-1:0]       imm_b,
    input  logic [`XLEN-1:0]       rs1_op,
    input  logic [`XLEN-1:0]       rs2_op,
    output id_pipe_pkg::redirect_t redirect
);

    import rv_isa_pkg::*;

    inst_fields_t     f;
    logic             is_br;
    logic             taken;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] fall_thru;

    assign f         = if_id.inst;
    assign is_br     = if_id.valid && (f.opcode == OP_BRANCH);
    assign target    = if_id.pc + imm_b;
    assign fall_thru = if_id.pc + `PC_STEP;

    always_comb begin
        case (f.funct3)
            3'b000:  taken = (rs1_op == rs2_op);
            3'b001:  taken = (rs1_op != rs2_op);
            3'b100:  taken = ($signed(rs1_op) < $signed(rs2_op));
            3'b101:  taken = ($signed(rs1_op) >= $signed(rs2_op));
            3'b110:  taken = (rs1_op < rs2_op);
            3'b111:  taken = (rs1_op >= rs2_op);
            default: taken = 1'b0;  // Reserved encodings never branch
        endcase
    end

    // Compare outcome with the fetch-stage guess
    always_comb begin
        redirect = '0;
        if (is_br) begin
            if (taken && (!if_id.prediction_valid || if_id.predicted_pc != target)) begin
                redirect.valid  = 1'b1;
                redirect.target = target;
            end else if (!taken && if_id.prediction_valid) begin
                redirect.valid  = 1'b1;  // Wrongly predicted taken
                redirect.target = fall_thru;
            end
        end
    end

    // Branch outcome needs known operands
    always_comb begin
        a_operands_known: assert final (!is_br || !$isunknown({rs1_op, rs2_op}))
            else $error("branch_resolver: branch operands unknown");
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  id_pipe_pkg::if_id_t    if_id,
    input  id_pipe_pkg::wb_t       wb,
    input  id_pipe_pkg::fwd_src_t  ex_mem_fwd,
    input  id_pipe_pkg::fwd_src_t  mem_wb_fwd,
    output id_pipe_pkg::id_ex_t    id_ex_next,
    output id_pipe_pkg::redirect_t redirect
);

    logic [1:0][`REG_IDX_W-1:0] src_idx;  // Lane 0 is rs1, lane 1 is rs2
    logic [1:0][`XLEN-1:0]      rf_data;
    logic [1:0][`XLEN-1:0]      br_op;    // Forwarded branch operands
    logic [`XLEN-1:0]           imm_b;

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rs1_idx  (src_idx[0]),
        .rs2_idx  (src_idx[1]),
        .rs1_data (rf_data[0]),
        .rs2_data (rf_data[1])
    );

    for (genvar lane = 0; lane < 2; lane++) begin : g_bypass
        operand_bypass u_bypass (
            .reg_idx    (src_idx[lane]),
            .reg_data   (rf_data[lane]),
            .ex_mem_fwd (ex_mem_fwd),
            .mem_wb_fwd (mem_wb_fwd),
            .wb_data    (wb.data),
            .operand    (br_op[lane])
        );
    end

    inst_decoder u_decoder (
        .flush      (flush),
        .if_id      (if_id),
        .rs1_data   (rf_data[0]),
        .rs2_data   (rf_data[1]),
        .rs1_idx    (src_idx[0]),
        .rs2_idx    (src_idx[1]),
        .imm_b      (imm_b),
        .id_ex_next (id_ex_next)
    );

    branch_resolver u_resolver (
        .if_id    (if_id),
        .imm_b    (imm_b),
        .rs1_op   (br_op[0]),
        .rs2_op   (br_op[1]),
        .redirect (redirect)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;

    always #5 clk = ~clk;  // 10 ns period

    // Reset held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tb_id_stage.sv
`timescale 1ns/1ps
`include "id_stage_params.svh"

module tb_id_stage;

    import id_pipe_pkg::*;
    import rv_isa_pkg::*;

    logic      clk;
    logic      rst;
    logic      flush;
    if_id_t    if_id;
    wb_t       wb;
    fwd_src_t  ex_mem_fwd;
    fwd_src_t  mem_wb_fwd;
    id_ex_t    id_ex_next;
    redirect_t redirect;

    // Vectors from the stim file
    if_id_t    vec_if_id [$];
    wb_t       vec_wb [$];
    fwd_src_t  vec_ex_mem [$];
    fwd_src_t  vec_mem_wb [$];
    logic      vec_flush [$];
    id_ex_t    exp_id_ex [$];
    redirect_t exp_redirect [$];
    int        num_vec = 0;

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    id_stage i_dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .if_id      (if_id),
        .wb         (wb),
        .ex_mem_fwd (ex_mem_fwd),
        .mem_wb_fwd (mem_wb_fwd),
        .id_ex_next (id_ex_next),
        .redirect   (redirect)
    );

    // RV32I branch funct3 encoding
    function automatic br_type_e branch_kind(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    // --------------------
    // Stim file reader
    // --------------------
    task automatic load_vectors();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [31:0] c [29];
        id_ex_t      e;
        if_id_t      d;
        fd = $fopen("id_stage_stim.txt", "r");
        line_no = 0;
        if (fd == 0) begin
            $display("Errors found");
            $fatal(1, "Could not open the stim file id_stage_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
            n = $sscanf(line,
                "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
                c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], c[18], c[19],
                c[20], c[21], c[22], c[23], c[24], c[25], c[26], c[27], c[28]);
            if (n != 29) begin
                $display("Errors found");
                $fatal(1, "Stim file line %0d has %0d columns instead of 29", line_no, n);
            end
            vec_wb.push_back('{enable: c[0][0], rd: c[1][4:0], data: c[2]});
            d = '{valid: c[3][0], pc: c[4], inst: c[5], prediction_valid: c[6][0],
                  predicted_pc: c[7]};
            vec_if_id.push_back(d);
            vec_flush.push_back(c[8][0]);
            vec_ex_mem.push_back('{valid: c[9][1], reg_write: c[9][0], rd: c[10][4:0],
                                   result: c[11]});
            vec_mem_wb.push_back('{valid: c[12][1], reg_write: c[12][0], rd: c[13][4:0],
                                   result: c[14]});
            e              = '0;
            e.valid        = c[15][0];
            e.pc           = d.pc;
            e.imm          = c[16];
            e.alu_op       = alu_op_e'(c[17][3:0]);
            e.alu_src1_sel = c[18][0];
            e.alu_src2_sel = c[19][0];
            e.reg_write    = c[20][0];
            e.mem_read     = c[21][0];
            e.mem_write    = c[22][0];
            e.mem_width    = mem_width_e'(c[23][1:0]);
            e.mem_unsigned = c[24][0];
            e.rs1_data     = c[25];
            e.rs2_data     = c[26];
            // Register fields and prediction pass straight through
            e.rd               = d.inst[11:7];
            e.rs1              = d.inst[19:15];
            e.rs2              = d.inst[24:20];
            e.prediction_valid = d.prediction_valid;
            e.predicted_pc     = d.predicted_pc;
            e.is_branch        = (d.inst[6:0] == 7'b1100011);
            e.is_jump          = (d.inst[6:0] == 7'b1101111)
                                 || (d.inst[6:0] == 7'b1100111);  // JAL or JALR
            e.branch_type      = e.is_branch ? branch_kind(d.inst[14:12]) : BR_NONE;
            if (!e.valid) begin
                e = '0;  // Killed or unsupported instruction
            end
            exp_id_ex.push_back(e);
            exp_redirect.push_back('{valid: c[27][0], target: c[28]});
            num_vec++;
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("Errors found");
            $fatal(1, "The stim file holds no vectors");
        end
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input int idx);
        if (got !== exp) begin
            $display("Error at %0t: vector %0d id_ex_next is %h", $time, idx, got);
            $display("  expected %h", exp);
            $display("Errors found");
            $fatal(1, "id_ex_next mismatch");
        end
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t exp, input int idx);
        if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
            $display("Error at %0t: vector %0d redirect valid=%0b target=%h",
                     $time, idx, got.valid, got.target);
            $display("  expected valid=%0b target=%h", exp.valid, exp.target);
            $display("Errors found");
            $fatal(1, "redirect mismatch");
        end
    endtask

    initial begin
        flush      = 1'b0;
        if_id      = '0;
        wb         = '0;
        ex_mem_fwd = '0;
        mem_wb_fwd = '0;
        load_vectors();
        @(negedge rst);
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            flush      <= vec_flush[i];
            if_id      <= vec_if_id[i];
            wb         <= vec_wb[i];
            ex_mem_fwd <= vec_ex_mem[i];
            mem_wb_fwd <= vec_mem_wb[i];
            @(negedge clk);  // Outputs settled by mid cycle
            check_id_ex(id_ex_next, exp_id_ex[i], i);
            check_redirect(redirect, exp_redirect[i], i);
        end
        $display("No errors");
        $finish;
    end

    // Watchdog sized from the vector count plus reset and margin
    initial begin
        wait (num_vec > 0);
        #((num_vec + 3 + 20) * 10);
        $display("Errors found");
        $fatal(1, "Timeout, the run did not finish in time");
    end

endmodule

// File: id_stage_stim.txt
# wb_en wb_rd wb_data if_valid pc inst pred_valid pred_pc flush exm_vw exm_rd exm_res mwb_vw mwb_rd mwb_res
# then expected: valid imm alu_op src1_pc src2_imm reg_write mem_rd mem_wr width unsigned rs1 rs2 redir target
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 2081B3 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 0 0
0 0 0 1 0 1EFE2B3 0 0 0 0 0 0 0 0 0 1 0 8 0 0 1 0 0 0 0 0 0 0 0
1 1 11 1 0 2081B3 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 11 0 0 0
1 2 FFFFFFF0 1 0 40208233 0 0 0 0 0 0 0 0 0 1 0 1 0 0 1 0 0 0 0 11 FFFFFFF0 0 0
1 0 DEADBEEF 1 0 1001B3 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 11 0 0
0 0 0 1 0 2001B3 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 FFFFFFF0 0 0
0 0 0 1 0 FFF08293 0 0 0 0 0 0 0 0 0 1 FFFFFFFF 0 0 1 1 0 0 0 0 11 0 0 0
0 0 0 1 0 40315313 0 0 0 0 0 0 0 0 0 1 403 7 0 1 1 0 0 0 0 FFFFFFF0 0 0 0
0 0 0 1 0 123453B7 0 0 0 0 0 0 0 0 0 1 12345000 A 0 1 1 0 0 0 0 0 0 0 0
0 0 0 1 100 FFFFF417 0 0 0 0 0 0 0 0 0 1 FFFFF000 B 1 1 1 0 0 0 0 0 0 0 0
0 0 0 1 200 FF9FF0EF 0 0 0 0 0 0 0 0 0 1 FFFFFFF8 0 1 1 1 0 0 0 0 0 0 0 0
0 0 0 1 0 1008067 0 0 0 0 0 0 0 0 0 1 10 0 0 1 1 0 0 0 0 11 0 0 0
0 0 0 1 0 FFC14483 0 0 0 0 0 0 0 0 0 1 FFFFFFFC 0 0 1 1 1 0 0 1 FFFFFFF0 0 0 0
0 0 0 1 0 209483 0 0 0 0 0 0 0 0 0 1 2 0 0 1 1 1 0 1 0 11 FFFFFFF0 0 0
0 0 0 1 0 FE20AA23 0 0 0 0 0 0 0 0 0 1 FFFFFFF4 0 0 1 0 0 1 2 0 11 FFFFFFF0 0 0
0 0 0 1 0 1103A3 0 0 0 0 0 0 0 0 0 1 7 0 0 1 0 0 1 0 0 FFFFFFF0 11 0 0
0 0 0 1 1000 208863 0 0 0 0 0 0 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 0 0
0 0 0 1 1000 208863 1 1010 0 0 0 0 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 1 1004
0 0 0 1 1000 209863 1 1010 0 0 0 0 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 0 0
0 0 0 1 1000 209863 1 1020 0 0 0 0 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 1 1010
0 0 5 1 1000 20C863 0 0 0 3 1 80000000 3 1 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 1 1010
0 0 0 1 1000 20E863 0 0 0 0 0 0 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 1 1010
0 0 20 1 1000 20D863 1 1010 0 2 2 0 3 2 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 1 1004
0 0 0 1 1000 20F863 1 1010 0 3 1 FFFFFFFF 0 0 0 1 10 0 1 1 0 0 0 0 0 11 FFFFFFF0 0 0
0 0 0 1 1000 FE0008E3 0 0 0 3 0 7 0 0 0 1 FFFFFFF0 0 1 1 0 0 0 0 0 0 0 1 FF0
0 0 0 1 0 73 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 2081B3 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 1000 FE0008E3 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 FF0
0 0 0 0 1000 FE0008E3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: id_stage.f
+incdir+.
rv_isa_pkg.sv
id_pipe_pkg.sv
reg_file.sv
inst_decoder.sv
operand_bypass.sv
branch_resolver.sv
id_stage.sv
tb_clock_gen.sv
tb_id_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_id_stage
FILELIST  = id_stage.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
